// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Request from the PC generator to the cache.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// The pc is always word aligned, so bits 1:0 are zero.
	typedef struct packed {
		logic [31:0] pc;
		logic        epoch; // Fetch generation, flipped by every redirect.
	} fetch_req_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Response from the cache to the instruction queue.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// The epoch is copied from the request unchanged, so the queue
	// can tell which words were fetched before the last redirect.
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] inst;  // Instruction word read at pc.
		logic        epoch;
	} fetch_rsp_t;

endpackage

// ==== hdl/cache_pkg.sv ====
package cache_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Cache geometry.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Four ways, tied to the width of the one-hot victim pointer.
	localparam int WAYS = 4;

	localparam int LINE_BYTES     = 16;
	localparam int WORDS_PER_LINE = LINE_BYTES / 4;

	// Byte offset inside a line. The word select is pc[OFFSET_BITS-1:2].
	localparam int OFFSET_BITS = $clog2(LINE_BYTES);

	// A whole line as it moves from the backing memory into a way.
	// Word 0 sits in the low 32 bits.
	typedef logic [WORDS_PER_LINE-1:0][31:0] line_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Controller states.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// IDLE has no request in the lookup stage.
	// LOOKUP compares tags for the held request.
	// REFILL waits for the line from the backing memory.
	// RESPOND is the fill cycle, where the new line answers the request.
	typedef enum logic [1:0] {
		IDLE,
		LOOKUP,
		REFILL,
		RESPOND
	} cache_state_e;

endpackage

// ==== hdl/fetch_pc_gen.sv ====
`timescale 1ns/1ns

module fetch_pc_gen #(
	parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 redirect_valid,
	input  logic [31:0]          redirect_pc,
	output fetch_pkg::fetch_req_t req,
	output logic                 req_valid,
	input  logic                 req_ready,
	output logic                 cur_epoch
);

	logic [31:0] pc;
	logic        epoch;
	logic        valid_q;
	logic        fire;

	assign fire = valid_q && req_ready;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// PC and epoch registers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (rst) begin
			pc      <= {RESET_PC[31:2], 2'b00};
			epoch   <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= 1'b1; // A request is offered every cycle once out of reset.
			if (redirect_valid) begin
				// A redirect wins over a stalled or accepted request.
				// Anything already in flight carries the old epoch.
				pc    <= {redirect_pc[31:2], 2'b00};
				epoch <= ~epoch;
			end else if (fire) begin
				pc <= pc + 32'd4;
			end
		end
	end

	assign req = '{pc: pc, epoch: epoch};
	assign req_valid = valid_q;

	// The queue compares returning words against this.
	assign cur_epoch = epoch;

endmodule

// ==== hdl/icache.sv ====
`timescale 1ns/1ns

module icache #(
	parameter int SETS = 64
) (
	input  logic                  clk,
	input  logic                  rst,
	input  fetch_pkg::fetch_req_t req,
	input  logic                  req_valid,
	output logic                  req_ready,
	output fetch_pkg::fetch_rsp_t rsp,
	output logic                  rsp_valid,
	input  logic                  rsp_ready,
	output logic                  refill_req,
	output logic [31:0]           refill_addr,
	input  logic                  refill_valid,
	input  cache_pkg::line_t      refill_line
);

	localparam int WAYS  = cache_pkg::WAYS;
	localparam int OFF_W = cache_pkg::OFFSET_BITS;
	localparam int IDX_W = $clog2(SETS);
	localparam int TAG_W = 32 - OFF_W - IDX_W; // 22 bits with 64 sets.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Storage.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	logic [TAG_W-1:0]         tag_arr  [WAYS][SETS];
	cache_pkg::line_t         data_arr [WAYS][SETS];
	logic [WAYS-1:0][SETS-1:0] valid_arr;

	cache_pkg::cache_state_e state, state_d;
	fetch_pkg::fetch_req_t   lk_req;  // Request held in the lookup stage.
	logic [WAYS-1:0]         victim;  // One-hot way chosen for the next miss.

	logic [IDX_W-1:0] lk_idx;
	logic [TAG_W-1:0] lk_tag;
	logic [WAYS-1:0]  way_hit;
	logic             lk_hit;
	logic             lk_active;
	cache_pkg::line_t hit_line;
	logic [31:0]      hit_word;
	logic             rsp_free;
	logic             emit;
	logic             fill;

	assign lk_idx = lk_req.pc[OFF_W +: IDX_W];
	assign lk_tag = lk_req.pc[31 -: TAG_W];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tag compare and word select.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		hit_line = '0;
		for (int w = 0; w < WAYS; w++) begin
			way_hit[w] = valid_arr[w][lk_idx] && (tag_arr[w][lk_idx] == lk_tag);
			if (way_hit[w]) begin
				hit_line = data_arr[w][lk_idx]; // At most one way matches.
			end
		end
	end

	assign lk_hit   = |way_hit;
	assign hit_word = hit_line[lk_req.pc[OFF_W-1:2]];

	// In RESPOND the line was just written, so the same compare hits.
	assign lk_active = (state == cache_pkg::LOOKUP) || (state == cache_pkg::RESPOND);
	assign rsp_free  = !rsp_valid || rsp_ready;
	assign emit      = lk_active && lk_hit && rsp_free;
	assign fill      = (state == cache_pkg::REFILL) && refill_valid;

	// A new request enters only when the lookup stage empties this cycle.
	assign req_ready = rsp_free && ((state == cache_pkg::IDLE) || (lk_active && lk_hit));

	assign refill_req  = lk_active && !lk_hit;
	assign refill_addr = {lk_req.pc[31:OFF_W], {OFF_W{1'b0}}};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Controller.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		state_d = state;
		case (state)
			cache_pkg::IDLE: begin
				if (req_valid && req_ready) state_d = cache_pkg::LOOKUP;
			end
			cache_pkg::LOOKUP, cache_pkg::RESPOND: begin
				if (!lk_hit) begin
					state_d = cache_pkg::REFILL;
				end else if (emit) begin
					state_d = req_valid ? cache_pkg::LOOKUP : cache_pkg::IDLE;
				end
			end
			cache_pkg::REFILL: begin
				if (refill_valid) state_d = cache_pkg::RESPOND;
			end
			default: state_d = cache_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= cache_pkg::IDLE;
			victim    <= 4'b0001;
			valid_arr <= '0;
			rsp_valid <= 1'b0;
		end else begin
			state <= state_d;
			if (fill) begin
				valid_arr[0][lk_idx] <= victim[0] | valid_arr[0][lk_idx];
				valid_arr[1][lk_idx] <= victim[1] | valid_arr[1][lk_idx];
				valid_arr[2][lk_idx] <= victim[2] | valid_arr[2][lk_idx];
				valid_arr[3][lk_idx] <= victim[3] | valid_arr[3][lk_idx];
				victim <= {victim[WAYS-2:0], victim[WAYS-1]}; // Once per miss.
			end
			if (emit) begin
				rsp_valid <= 1'b1;
			end else if (rsp_ready) begin
				rsp_valid <= 1'b0;
			end
		end
	end

	// Payload registers and line storage.
	always_ff @(posedge clk) begin
		if (req_valid && req_ready) lk_req <= req;
		if (emit) rsp <= '{pc: lk_req.pc, inst: hit_word, epoch: lk_req.epoch};
		for (int w = 0; w < WAYS; w++) begin
			if (fill && victim[w]) begin
				tag_arr[w][lk_idx]  <= lk_tag;
				data_arr[w][lk_idx] <= refill_line;
			end
		end
	end

endmodule

// ==== hdl/refill_mem.sv ====
`timescale 1ns/1ns

module refill_mem #(
	parameter int MEM_WORDS      = 4096,
	parameter int REFILL_LATENCY = 4
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             load_valid,
	input  logic [31:0]      load_addr,
	input  logic [31:0]      load_data,
	input  logic             refill_req,
	input  logic [31:0]      refill_addr,
	output logic             refill_valid,
	output cache_pkg::line_t refill_line
);

	// Addresses wrap modulo MEM_WORDS, which is a power of two.
	localparam int AW      = $clog2(MEM_WORDS);
	localparam int LINE_AW = AW - $clog2(cache_pkg::WORDS_PER_LINE);

	logic [31:0] mem [MEM_WORDS];

	// Delay line for the one outstanding read.
	logic [REFILL_LATENCY-1:0] pend_v;
	logic [LINE_AW-1:0]        pend_line [REFILL_LATENCY];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Word load port.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (load_valid) mem[load_addr[AW+1:2]] <= load_data;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Fixed-latency line read.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (rst) begin
			pend_v <= '0;
		end else begin
			pend_v[0] <= refill_req;
			for (int i = 1; i < REFILL_LATENCY; i++) begin
				pend_v[i] <= pend_v[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		pend_line[0] <= refill_addr[AW+1:cache_pkg::OFFSET_BITS];
		for (int i = 1; i < REFILL_LATENCY; i++) begin
			pend_line[i] <= pend_line[i-1];
		end
	end

	// The line leaves the last stage, REFILL_LATENCY cycles after the request.
	assign refill_valid = pend_v[REFILL_LATENCY-1];

	always_comb begin
		for (int i = 0; i < cache_pkg::WORDS_PER_LINE; i++) begin
			refill_line[i] = mem[{pend_line[REFILL_LATENCY-1], 2'(i)}];
		end
	end

endmodule

// ==== hdl/inst_queue.sv ====
`timescale 1ns/1ns

module inst_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                  clk,
	input  logic                  rst,
	input  fetch_pkg::fetch_rsp_t rsp,
	input  logic                  rsp_valid,
	output logic                  rsp_ready,
	input  logic                  cur_epoch,
	input  logic                  redirect_valid,
	output logic [31:0]           out_pc,
	output logic [31:0]           out_inst,
	output logic                  out_valid,
	input  logic                  out_ready
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

	logic [31:0] pc_mem   [QUEUE_DEPTH];
	logic [31:0] inst_mem [QUEUE_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             keep;
	logic             push;
	logic             pop;

	// Pointer step with wrap, so the depth need not be a power of two.
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign rsp_ready = (count != (PTR_W+1)'(QUEUE_DEPTH));
	assign keep      = (rsp.epoch == cur_epoch); // Stale words are taken and dropped.
	assign push      = rsp_valid && rsp_ready && keep;
	assign pop       = out_valid && out_ready;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pointers and fill level.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (rst || redirect_valid) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) wr_ptr <= next_ptr(wr_ptr);
			if (pop)  rd_ptr <= next_ptr(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			pc_mem[wr_ptr]   <= rsp.pc;
			inst_mem[wr_ptr] <= rsp.inst;
		end
	end

	assign out_valid = (count != '0);
	assign out_pc    = pc_mem[rd_ptr];
	assign out_inst  = inst_mem[rd_ptr];

endmodule

// ==== hdl/fetch_top.sv ====
`timescale 1ns/1ns

module fetch_top #(
	parameter logic [31:0] RESET_PC       = 32'h0000_0000,
	parameter int          SETS           = 64,
	parameter int          MEM_WORDS      = 4096,
	parameter int          REFILL_LATENCY = 4,
	parameter int          QUEUE_DEPTH    = 4
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        load_valid,
	input  logic [31:0] load_addr,
	input  logic [31:0] load_data,
	input  logic        redirect_valid,
	input  logic [31:0] redirect_pc,
	output logic [31:0] out_pc,
	output logic [31:0] out_inst,
	output logic        out_valid,
	input  logic        out_ready
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Internal channels.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	fetch_pkg::fetch_req_t req;
	logic                  req_valid;
	logic                  req_ready;
	fetch_pkg::fetch_rsp_t rsp;
	logic                  rsp_valid;
	logic                  rsp_ready;
	logic                  cur_epoch;

	logic                  refill_req;
	logic [31:0]           refill_addr;
	logic                  refill_valid;
	cache_pkg::line_t      refill_line;

	fetch_pc_gen #(.RESET_PC(RESET_PC)) u_pc_gen (
		.clk, .rst, .redirect_valid, .redirect_pc,
		.req, .req_valid, .req_ready, .cur_epoch
	);

	icache #(.SETS(SETS)) u_icache (
		.clk, .rst, .req, .req_valid, .req_ready,
		.rsp, .rsp_valid, .rsp_ready,
		.refill_req, .refill_addr, .refill_valid, .refill_line
	);

	refill_mem #(.MEM_WORDS(MEM_WORDS), .REFILL_LATENCY(REFILL_LATENCY)) u_mem (
		.clk, .rst, .load_valid, .load_addr, .load_data,
		.refill_req, .refill_addr, .refill_valid, .refill_line
	);

	// The queue flushes on the same edge that the PC generator redirects.
	inst_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
		.clk, .rst, .rsp, .rsp_valid, .rsp_ready, .cur_epoch, .redirect_valid,
		.out_pc, .out_inst, .out_valid, .out_ready
	);

endmodule

// ==== tb/fetch_checker.sv ====
`timescale 1ns/1ns

module fetch_checker (
	input logic                    clk,
	input logic                    rst,
	input fetch_pkg::fetch_req_t   req,
	input logic                    req_valid,
	input logic                    req_ready,
	input fetch_pkg::fetch_rsp_t   rsp,
	input logic                    rsp_valid,
	input logic                    rsp_ready,
	input logic                    refill_req,
	input cache_pkg::cache_state_e state,
	input logic                    out_valid
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Handshake stability.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// A redirect may replace a stalled request; it always flips the epoch.
	a_req_hold: assert property (@(posedge clk) disable iff (rst)
		req_valid && !req_ready |=> $stable(req) || (req.epoch != $past(req.epoch)))
		else $error("Fetch request changed while stalled.");

	a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
		else $error("Fetch response changed or dropped while stalled.");

	// A refill starts only from a first lookup. The fill cycle must hit the line it wrote.
	a_refill_state: assert property (@(posedge clk) disable iff (rst)
		refill_req |-> (state == cache_pkg::LOOKUP))
		else $error("Refill requested outside a first lookup.");

	a_reset_quiet: assert property (@(posedge clk)
		rst && $past(rst) |-> !out_valid)
		else $error("Output valid during reset.");

endmodule

bind icache fetch_checker u_cache_chk (
	.clk, .rst, .req, .req_valid, .req_ready,
	.rsp, .rsp_valid, .rsp_ready,
	.refill_req, .state, .out_valid(rsp_valid)
);

bind inst_queue fetch_checker u_queue_chk (
	.clk, .rst, .req('0), .req_valid(1'b0), .req_ready(1'b0),
	.rsp, .rsp_valid, .rsp_ready,
	.refill_req(1'b0), .state(cache_pkg::IDLE), .out_valid
);

// ==== tb/fetch_tb.sv ====
`timescale 1ns/1ns

module fetch_tb;

	localparam logic [31:0] RESET_PC       = 32'h0000_0000;
	localparam int          SETS           = 64;
	localparam int          MEM_WORDS      = 4096;
	localparam int          REFILL_LATENCY = 4;
	localparam int          QUEUE_DEPTH    = 4;

	// Words consumed by each test, in order: straight, back-pressure,
	// random redirects, loop, eviction.
	localparam int TEST_WORDS     = 128 + 256 + 96 + 48 + 36;
	localparam int TIMEOUT_CYCLES = TEST_WORDS * (REFILL_LATENCY + 3) + 2000;

	localparam logic [31:0] LOOP_BASE   = 32'h0000_2000;
	localparam logic [31:0] LOOP_LAST   = LOOP_BASE + 32'd28; // Eighth word of the loop.
	localparam int          LOOP_PASSES = 6;
	localparam logic [31:0] EVICT_BASE  = 32'h0000_0940;
	localparam int          SET_STRIDE  = SETS * 16;          // Same set, next tag.

	logic        clk;
	logic        rst;
	logic        load_valid;
	logic [31:0] load_addr;
	logic [31:0] load_data;
	logic        redirect_valid;
	logic [31:0] redirect_pc;
	logic [31:0] out_pc;
	logic [31:0] out_inst;
	logic        out_valid;
	logic        out_ready;

	logic [31:0] mem_copy [MEM_WORDS];
	logic [31:0] lfsr_state;
	logic [31:0] exp_pc;
	string       cur_test;
	int          cycles;
	int          n_out;
	int          last_out_cycle;
	int          gap;
	logic        took;
	logic [31:0] took_pc;

	fetch_top #(
		.RESET_PC(RESET_PC),
		.SETS(SETS),
		.MEM_WORDS(MEM_WORDS),
		.REFILL_LATENCY(REFILL_LATENCY),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) i_dut (
		.clk, .rst, .load_valid, .load_addr, .load_data,
		.redirect_valid, .redirect_pc,
		.out_pc, .out_inst, .out_valid, .out_ready
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Helpers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Fibonacci LFSR with taps 32, 22, 2 and 1, stepped once per bit.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("mismatch %s expected %h actual %h", name, exp, act);
			$display("TESTBENCH FAILED");
			$fatal(1, "value check failed");
		end
	endtask

	// One clock edge. Outputs are sampled before the edge updates them,
	// and every accepted word is compared with the reference model.
	task automatic step();
		@(posedge clk);
		cycles++;
		took = 1'b0;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("The run timed out after %0d cycles in test %s.", cycles, cur_test);
			$display("TESTBENCH FAILED");
			$fatal(1, "timeout");
		end
		if (out_valid && out_ready) begin
			check_val({cur_test, " pc"}, exp_pc, out_pc);
			check_val({cur_test, " word"}, mem_copy[(exp_pc >> 2) % MEM_WORDS], out_inst);
			took           = 1'b1;
			took_pc        = out_pc;
			gap            = cycles - last_out_cycle;
			last_out_cycle = cycles;
			n_out++;
			exp_pc += 32'd4;
		end
		if (redirect_valid) exp_pc = redirect_pc; // Words taken on this edge are still old.
		redirect_valid <= 1'b0;
	endtask

	task automatic do_redirect(input logic [31:0] pc);
		step();
		redirect_valid <= 1'b1;
		redirect_pc    <= pc;
	endtask

	task automatic run_words(input int n, input logic backpressure);
		int target;
		target = n_out + n;
		while (n_out < target) begin
			step();
			out_ready <= backpressure ? (rand_bits(1) != 0) : 1'b1;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Test sequence.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		logic [31:0] word;
		logic        done;
		rst            = 1'b1;
		load_valid     = 1'b0;
		load_addr      = '0;
		load_data      = '0;
		redirect_valid = 1'b0;
		redirect_pc    = '0;
		out_ready      = 1'b1;
		lfsr_state     = 32'hdaa6_94b4;
		cycles         = 0;
		n_out          = 0;
		last_out_cycle = 0;
		gap            = 0;
		took           = 1'b0;
		took_pc        = '0;
		cur_test       = "preload";

		// The whole memory is written while the core is held in reset.
		for (int i = 0; i < MEM_WORDS; i++) begin
			@(posedge clk);
			word = rand_bits(32);
			load_valid  <= 1'b1;
			load_addr   <= 32'(i * 4);
			load_data   <= word;
			mem_copy[i] = word;
		end
		@(posedge clk);
		load_valid <= 1'b0;
		repeat (10) @(posedge clk);
		rst    <= 1'b0;
		exp_pc = {RESET_PC[31:2], 2'b00};

		cur_test = "straight";
		run_words(128, 1'b0);

		cur_test = "backpressure";
		run_words(256, 1'b1);

		cur_test = "redirect";
		for (int r = 0; r < 24; r++) begin
			do_redirect(rand_bits(30) << 2);
			run_words(1 + int'(rand_bits(2)), 1'b1);
		end

		// Passes after the first hit in every line, so words must stream.
		cur_test = "loop";
		do_redirect(LOOP_BASE);
		for (int pass = 0; pass < LOOP_PASSES; pass++) begin
			done = 1'b0;
			while (!done) begin
				step();
				out_ready <= 1'b1;
				if (took && pass >= 1 && took_pc > LOOP_BASE && took_pc <= LOOP_LAST) begin
					check_val("loop spacing", 32'd1, 32'(gap));
				end
				if (took && took_pc == LOOP_LAST) begin
					done = 1'b1;
					// A one-bit epoch cannot tell apart words from two redirects ago.
					// The last pass falls through into the eviction test.
					if (pass < LOOP_PASSES - 1) begin
						redirect_valid <= 1'b1;
						redirect_pc    <= LOOP_BASE;
					end
				end
			end
		end

		// Six tags in one set of four ways, fetched three rounds.
		cur_test = "eviction";
		for (int round = 0; round < 3; round++) begin
			for (int k = 0; k < 6; k++) begin
				do_redirect(EVICT_BASE + 32'(k * SET_STRIDE));
				run_words(2, 1'b0);
			end
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== compile.f ====
hdl/fetch_pkg.sv
hdl/cache_pkg.sv
hdl/fetch_pc_gen.sv
hdl/icache.sv
hdl/refill_mem.sv
hdl/inst_queue.sv
hdl/fetch_top.sv
tb/fetch_checker.sv
tb/fetch_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = fetch_tb
FILELIST  = compile.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
